/* Bender.yml */
package:
  name: zxuno_regbank

sources:
  - src/zxuno_pkg.sv
  - src/zxuno_regaddr.sv
  - src/zxuno_cfg_reg.sv
  - src/core_id.sv
  - src/zxuno_regbank.sv
  - target: test
    files:
      - test/tb_zxuno_regbank.sv

/* all.f */
src/zxuno_pkg.sv
src/zxuno_regaddr.sv
src/zxuno_cfg_reg.sv
src/core_id.sv
src/zxuno_regbank.sv
test/tb_zxuno_regbank.sv

/* src/core_id.sv */
module core_id import zxuno_pkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  regbus_t regbus,
   input  logic    regaddr_changed,
   output byte_t   dout,
   output logic    oe_n
);

   // Index runs 0..coreid_len, the last value is the terminator
   logic [coreid_idx_w-1:0] char_idx;
   logic                    rd_hit;
   logic                    rd_hit_q;
   logic                    rd_end;

   assign rd_hit = regbus.regrd && (regbus.addr == reg_coreid);

   // First cycle after a matched read has dropped
   assign rd_end = rd_hit_q && !rd_hit;

   // ----------------------------------------------------------
   // Character index
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_hit_q <= 1'b0;
         char_idx <= '0;
      end else begin
         rd_hit_q <= rd_hit;
         if (regaddr_changed) begin
            char_idx <= '0;
         end else if (rd_end) begin
            if (char_idx == coreid_len) begin
               char_idx <= '0;
            end else begin
               char_idx <= char_idx + 1'b1;
            end
         end
      end
   end

   // ----------------------------------------------------------
   // Character select
   // ----------------------------------------------------------
   always_comb begin
      if (char_idx < coreid_len) begin
         // String is stored first character high
         dout = coreid_string[8*(coreid_len - 1 - int'(char_idx)) +: 8];
      end else begin
         dout = 8'h00;
      end
   end

   assign oe_n = !rd_hit;

endmodule

/* src/zxuno_cfg_reg.sv */
module zxuno_cfg_reg import zxuno_pkg::*; #(
   parameter type     reg_t       = byte_t,
   parameter regnum_t reg_addr    = reg_scratch,
   parameter reg_t    reset_value = '0
) (
   input  logic    clk,
   input  logic    reset,
   input  regbus_t regbus,
   output reg_t    value,
   output byte_t   dout,
   output logic    oe_n
);

   // Payload width, at most one byte
   localparam int width = $bits(reg_t);

   logic sel;

   assign sel = (regbus.addr == reg_addr);

   // ----------------------------------------------------------
   // Register write from the low bits of the data byte
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         value <= reset_value;
      end else if (regbus.regwr && sel) begin
         value <= reg_t'(regbus.wdata[width-1:0]);
      end
   end

   // ----------------------------------------------------------
   // Readback, zero-extended to a byte
   // ----------------------------------------------------------
   always_comb begin
      dout = '0;
      dout[width-1:0] = value;
   end

   assign oe_n = !(regbus.regrd && sel);

endmodule

/* src/zxuno_pkg.sv */
package zxuno_pkg;

   // Basic bus types
   typedef logic [15:0] cpu_addr_t;
   typedef logic [7:0]  byte_t;
   typedef logic [7:0]  regnum_t;

   // ----------------------------------------------------------
   // I/O ports decoded on the full 16-bit address
   // ----------------------------------------------------------
   localparam cpu_addr_t zxuno_addr_port = 16'hFC3B;
   localparam cpu_addr_t zxuno_data_port = 16'hFD3B;

   // ----------------------------------------------------------
   // Register numbers behind the data port
   // ----------------------------------------------------------
   localparam regnum_t reg_rasterline = 8'h0C;
   localparam regnum_t reg_rasterctrl = 8'h0D;
   localparam regnum_t reg_devoptions = 8'h0E;
   localparam regnum_t reg_scratch    = 8'hFE;
   localparam regnum_t reg_coreid     = 8'hFF;

   // Device enable flags, MSB first
   typedef struct packed {
      logic disable_ay;
      logic disable_turboay;
      logic disable_7ffd;
      logic disable_1ffd;
      logic disable_romsel7f;
      logic disable_romsel1f;
      logic enable_timexmmu;
      logic disable_spisd;
   } devoptions_t;

   // Raster control, read back zero-extended
   typedef struct packed {
      logic line_msb;
      logic vretraceint_disable;
      logic rasterint_enable;
   } rasterctrl_t;

   // Raster interrupt settings handed to the video side
   typedef struct packed {
      logic       rasterint_enable;
      logic       vretraceint_disable;
      logic [8:0] raster_line;
   } rasterint_cfg_t;

   // Register-side bus shared by all register blocks
   typedef struct packed {
      regnum_t addr;
      logic    regrd;
      logic    regwr;
      byte_t   wdata;
   } regbus_t;

   // Reset values
   localparam byte_t       scratch_reset    = 8'h00;
   localparam devoptions_t devoptions_reset = '0;
   localparam byte_t       rasterline_reset = 8'hFF;
   localparam rasterctrl_t rasterctrl_reset = '0;

   // Core identification string, first character in the top byte
   localparam int coreid_len = 8;
   localparam int coreid_idx_w = $clog2(coreid_len + 1);
   localparam logic [8*coreid_len-1:0] coreid_string = "ZXREG-V1";

endpackage

/* src/zxuno_regaddr.sv */
module zxuno_regaddr import zxuno_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  cpu_addr_t a,
   input  logic      iorq_n,
   input  logic      rd_n,
   input  logic      wr_n,
   input  byte_t     din,
   output regbus_t   regbus,
   output logic      regaddr_changed,
   output byte_t     dout,
   output logic      oe_n
);

   // Write side of the current access, kept for edge detection
   typedef struct packed {
      logic addr_wr;
      logic data_wr;
   } wr_access_t;

   wr_access_t wr_access;
   wr_access_t wr_access_q;
   regnum_t    regaddr;
   logic       addr_port_sel;
   logic       data_port_sel;
   logic       addr_rd;
   logic       data_rd;
   logic       addr_wr_first;
   logic       data_wr_first;

   // ----------------------------------------------------------
   // Port decode
   // ----------------------------------------------------------
   assign addr_port_sel = !iorq_n && (a == zxuno_addr_port);
   assign data_port_sel = !iorq_n && (a == zxuno_data_port);

   assign addr_rd = addr_port_sel && !rd_n;
   assign data_rd = data_port_sel && !rd_n;

   always_comb begin
      wr_access.addr_wr = addr_port_sel && !wr_n;
      wr_access.data_wr = data_port_sel && !wr_n;
   end

   // First cycle of a write access only
   assign addr_wr_first = wr_access.addr_wr && !wr_access_q.addr_wr;
   assign data_wr_first = wr_access.data_wr && !wr_access_q.data_wr;

   // ----------------------------------------------------------
   // Address register and previous access state
   // ----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_access_q <= '0;
         regaddr     <= '0;
      end else begin
         wr_access_q <= wr_access;
         if (addr_wr_first) begin
            regaddr <= din;
         end
      end
   end

   assign regaddr_changed = addr_wr_first;

   // Read level lasts the whole access, write is a single pulse
   assign regbus = '{
      addr:  regaddr,
      regrd: data_rd,
      regwr: data_wr_first,
      wdata: din
   };

   // Address port readback
   assign dout = regaddr;
   assign oe_n = !addr_rd;

endmodule

/* src/zxuno_regbank.sv */
module zxuno_regbank import zxuno_pkg::*; (
   input  logic           clk,
   input  logic           reset,

   // CPU bus
   input  cpu_addr_t      a,
   input  logic           iorq_n,
   input  logic           rd_n,
   input  logic           wr_n,
   input  byte_t          din,
   output byte_t          dout,
   output logic           oe_n,

   // Settings for the rest of the machine
   output devoptions_t    devoptions,
   output rasterint_cfg_t rasterint_cfg
);

   regbus_t regbus;
   logic    regaddr_changed;

   // Read sources
   byte_t zxunoaddr_dout;
   logic  oe_n_zxunoaddr;
   byte_t scratch_dout;
   logic  oe_n_scratch;
   byte_t devoptions_dout;
   logic  oe_n_devoptions;
   byte_t rasterline_dout;
   logic  oe_n_rasterline;
   byte_t rasterctrl_dout;
   logic  oe_n_rasterctrl;
   byte_t coreid_dout;
   logic  oe_n_coreid;

   // Register contents
   byte_t       raster_line_lo;
   rasterctrl_t rasterctrl;

   // ----------------------------------------------------------
   // Address register and port decode
   // ----------------------------------------------------------
   zxuno_regaddr addr_reg_zxuno (
      .clk             (clk),
      .reset           (reset),
      .a               (a),
      .iorq_n          (iorq_n),
      .rd_n            (rd_n),
      .wr_n            (wr_n),
      .din             (din),
      .regbus          (regbus),
      .regaddr_changed (regaddr_changed),
      .dout            (zxunoaddr_dout),
      .oe_n            (oe_n_zxunoaddr)
   );

   // ----------------------------------------------------------
   // Configuration registers
   // ----------------------------------------------------------
   zxuno_cfg_reg #(
      .reg_t       (byte_t),
      .reg_addr    (reg_scratch),
      .reset_value (scratch_reset)
   ) scratch (
      .clk    (clk),
      .reset  (reset),
      .regbus (regbus),
      .value  (),
      .dout   (scratch_dout),
      .oe_n   (oe_n_scratch)
   );

   zxuno_cfg_reg #(
      .reg_t       (devoptions_t),
      .reg_addr    (reg_devoptions),
      .reset_value (devoptions_reset)
   ) device_enables (
      .clk    (clk),
      .reset  (reset),
      .regbus (regbus),
      .value  (devoptions),
      .dout   (devoptions_dout),
      .oe_n   (oe_n_devoptions)
   );

   zxuno_cfg_reg #(
      .reg_t       (byte_t),
      .reg_addr    (reg_rasterline),
      .reset_value (rasterline_reset)
   ) raster_line_reg (
      .clk    (clk),
      .reset  (reset),
      .regbus (regbus),
      .value  (raster_line_lo),
      .dout   (rasterline_dout),
      .oe_n   (oe_n_rasterline)
   );

   zxuno_cfg_reg #(
      .reg_t       (rasterctrl_t),
      .reg_addr    (reg_rasterctrl),
      .reset_value (rasterctrl_reset)
   ) raster_ctrl_reg (
      .clk    (clk),
      .reset  (reset),
      .regbus (regbus),
      .value  (rasterctrl),
      .dout   (rasterctrl_dout),
      .oe_n   (oe_n_rasterctrl)
   );

   core_id core_ident (
      .clk             (clk),
      .reset           (reset),
      .regbus          (regbus),
      .regaddr_changed (regaddr_changed),
      .dout            (coreid_dout),
      .oe_n            (oe_n_coreid)
   );

   // Line MSB lives in the control register
   always_comb begin
      rasterint_cfg.rasterint_enable    = rasterctrl.rasterint_enable;
      rasterint_cfg.vretraceint_disable = rasterctrl.vretraceint_disable;
      rasterint_cfg.raster_line         = {rasterctrl.line_msb, raster_line_lo};
   end

   // ----------------------------------------------------------
   // CPU read data, first active source wins
   // ----------------------------------------------------------
   always_comb begin
      case (1'b0)
         oe_n_zxunoaddr  : dout = zxunoaddr_dout;
         oe_n_scratch    : dout = scratch_dout;
         oe_n_devoptions : dout = devoptions_dout;
         oe_n_rasterline : dout = rasterline_dout;
         oe_n_rasterctrl : dout = rasterctrl_dout;
         oe_n_coreid     : dout = coreid_dout;
         default         : dout = 8'hFF;
      endcase
   end

   assign oe_n = oe_n_zxunoaddr & oe_n_scratch & oe_n_devoptions &
                 oe_n_rasterline & oe_n_rasterctrl & oe_n_coreid;

endmodule

/* test/tb_zxuno_regbank.sv */
module tb_zxuno_regbank import zxuno_pkg::*; ();

   localparam int period       = 100;
   localparam int max_accesses = 500;

   logic           clk = 1'b0;
   logic           reset;
   cpu_addr_t      a;
   logic           iorq_n;
   logic           rd_n;
   logic           wr_n;
   byte_t          din;
   byte_t          dout;
   logic           oe_n;
   devoptions_t    devoptions;
   rasterint_cfg_t rasterint_cfg;

   // Reference model state
   regnum_t     m_addr;
   byte_t       m_scratch;
   devoptions_t m_devopt;
   byte_t       m_rline;
   rasterctrl_t m_rctrl;
   int          m_idx;
   string       id_text = "ZXREG-V1";

   int          seed;
   regnum_t     r;
   cpu_addr_t   other_addr;
   regnum_t     impl_regs [4] = '{reg_scratch, reg_devoptions, reg_rasterline, reg_rasterctrl};

   always #(period/2) clk = ~clk;

   zxuno_regbank zxuno_regbank_inst (
      .clk           (clk),
      .reset         (reset),
      .a             (a),
      .iorq_n        (iorq_n),
      .rd_n          (rd_n),
      .wr_n          (wr_n),
      .din           (din),
      .dout          (dout),
      .oe_n          (oe_n),
      .devoptions    (devoptions),
      .rasterint_cfg (rasterint_cfg)
   );

   task check_value(input string name, input logic [15:0] actual, input logic [15:0] expected);
      if (actual !== expected) begin
         $display("Fail at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
         $display("TESTBENCH FAILED");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   // ----------------------------------------------------------
   // Reference model
   // ----------------------------------------------------------
   // Top bit is the expected oe_n, low byte the expected data
   function automatic logic [8:0] expected_read(input cpu_addr_t addr);
      logic [8:0] res;
      res = 9'h1FF;
      if (addr == zxuno_addr_port) begin
         res = {1'b0, m_addr};
      end else if (addr == zxuno_data_port) begin
         case (m_addr)
            reg_scratch    : res = {1'b0, m_scratch};
            reg_devoptions : res = {1'b0, m_devopt};
            reg_rasterline : res = {1'b0, m_rline};
            reg_rasterctrl : res = {1'b0, 5'b00000, m_rctrl};
            reg_coreid     : res = {1'b0, (m_idx < 8) ? id_text[m_idx] : 8'h00};
            default        : res = 9'h1FF;
         endcase
      end
      return res;
   endfunction

   task update_model_write(input cpu_addr_t addr, input byte_t data);
      if (addr == zxuno_addr_port) begin
         m_addr = data;
         m_idx  = 0;
      end else if (addr == zxuno_data_port) begin
         case (m_addr)
            reg_scratch    : m_scratch = data;
            reg_devoptions : m_devopt  = data;
            reg_rasterline : m_rline   = data;
            reg_rasterctrl : m_rctrl   = data[2:0];
            default        : ;
         endcase
      end
   endtask

   task check_settings();
      check_value("devoptions", devoptions, m_devopt);
      check_value("rasterint_cfg", rasterint_cfg,
                  {m_rctrl.rasterint_enable, m_rctrl.vretraceint_disable,
                   m_rctrl.line_msb, m_rline});
   endtask

   // ----------------------------------------------------------
   // One bus access of 1 to 3 cycles plus an idle cycle
   // ----------------------------------------------------------
   task bus_access(input cpu_addr_t addr, input logic is_write, input byte_t data);
      int         cycles;
      int         i;
      logic [8:0] expected;
      cycles   = $urandom_range(1, 3);
      expected = is_write ? 9'h1FF : expected_read(addr);
      a      = addr;
      din    = data;
      iorq_n = 1'b0;
      rd_n   = is_write;
      wr_n   = !is_write;
      for (i = 0; i < cycles; i++) begin
         @(negedge clk);
         // Write lands once, at the first edge of the access
         if (is_write && i == 0) begin
            update_model_write(addr, data);
         end
         check_value("oe_n", oe_n, expected[8]);
         check_value("dout", dout, expected[7:0]);
         check_settings();
         // Later write cycles carry other data, which must not land
         if (is_write) begin
            din = ~data;
         end
      end
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      wr_n   = 1'b1;
      din    = byte_t'($urandom);
      if (!is_write && addr == zxuno_data_port && m_addr == reg_coreid) begin
         m_idx = (m_idx == 8) ? 0 : m_idx + 1;
      end
      @(negedge clk);
      check_settings();
   endtask

   initial begin
      #(max_accesses * 5 * period + 20 * period);
      $display("Timeout: the bus accesses did not complete in the expected time");
      $display("TESTBENCH FAILED");
      $fatal(1, "Watchdog expired");
   end

   initial begin
      seed      = $urandom(32'h65aa_fb8c);
      reset     = 1'b1;
      a         = '0;
      iorq_n    = 1'b1;
      rd_n      = 1'b1;
      wr_n      = 1'b1;
      din       = '0;
      m_addr    = 8'h00;
      m_scratch = scratch_reset;
      m_devopt  = '0;
      m_rline   = 8'hFF;
      m_rctrl   = '0;
      m_idx     = 0;
      repeat (2) @(negedge clk);
      reset = 1'b0;

      // State right after reset
      check_value("oe_n", oe_n, 1'b1);
      check_value("devoptions", devoptions, 8'h00);
      check_value("rasterint_cfg", rasterint_cfg, 11'h0FF);
      bus_access(zxuno_addr_port, 1'b0, 8'h00);

      // Address register readback
      repeat (20) begin
         bus_access(zxuno_addr_port, 1'b1, byte_t'($urandom));
         bus_access(zxuno_addr_port, 1'b0, 8'h00);
      end

      // Random traffic to the configuration registers
      repeat (100) begin
         bus_access(zxuno_addr_port, 1'b1, impl_regs[$urandom_range(0, 3)]);
         repeat (2) bus_access(zxuno_data_port, 1'($urandom_range(0, 1)), byte_t'($urandom));
      end

      // Core ID string, wrap and restart
      bus_access(zxuno_addr_port, 1'b1, reg_coreid);
      repeat (20) bus_access(zxuno_data_port, 1'b0, 8'h00);
      bus_access(zxuno_addr_port, 1'b1, reg_coreid);
      repeat (3) bus_access(zxuno_data_port, 1'b0, 8'h00);
      bus_access(zxuno_addr_port, 1'b1, reg_scratch);
      bus_access(zxuno_addr_port, 1'b1, reg_coreid);
      repeat (10) bus_access(zxuno_data_port, 1'b0, 8'h00);

      // Unimplemented registers and foreign I/O addresses
      repeat (20) begin
         do r = regnum_t'($urandom);
         while (r inside {reg_rasterline, reg_rasterctrl, reg_devoptions, reg_scratch, reg_coreid});
         bus_access(zxuno_addr_port, 1'b1, r);
         bus_access(zxuno_data_port, 1'b1, byte_t'($urandom));
         bus_access(zxuno_data_port, 1'b0, 8'h00);
      end
      repeat (20) begin
         do other_addr = cpu_addr_t'($urandom);
         while (other_addr == zxuno_addr_port || other_addr == zxuno_data_port);
         bus_access(other_addr, 1'($urandom_range(0, 1)), byte_t'($urandom));
      end
      foreach (impl_regs[k]) begin
         bus_access(zxuno_addr_port, 1'b1, impl_regs[k]);
         bus_access(zxuno_data_port, 1'b0, 8'h00);
      end

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule
